// ==== src/muldiv_pkg.sv ====
// ------------------------------------------------
// shared definitions for the multiply/divide unit
// function codes, default operand width and decode helpers
// ------------------------------------------------
package muldiv_pkg;

  // default operand width of the core
  parameter int xlen_default = 32;

  // width of the request function code
  localparam int fn_w = 2;

  // request function codes
  // mul/div treat operands as two's complement, mulu/divu as unsigned
  typedef enum logic [fn_w-1:0] {
    fn_mul  = 2'd0,
    fn_mulu = 2'd1,
    fn_div  = 2'd2,
    fn_divu = 2'd3
  } muldiv_fn_e;

  // true for the two codes served by the divider
  function automatic logic fn_is_div(input muldiv_fn_e fn);
    fn_is_div = (fn == fn_div) || (fn == fn_divu);
  endfunction

endpackage

// ==== src/int_mul_iterative.sv ====
// ------------------------------------------------
// iterative shift-and-add multiplier, one bit per cycle
// valid/ready request in, full 2*xlen product out
// ------------------------------------------------
module int_mul_iterative #(
  parameter int xlen = muldiv_pkg::xlen_default
) (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::muldiv_fn_e fn,
  input  logic [xlen-1:0]        a,
  input  logic [xlen-1:0]        b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output logic [2*xlen-1:0]      result,
  output logic                   resp_val,
  input  logic                   resp_rdy
);
  localparam int cnt_w = $clog2(xlen);

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_e;

  state_e            state_q;
  logic [cnt_w-1:0]  cnt_q;
  logic              cnt_expired_q;
  logic [2*xlen-1:0] mcand_q;
  logic [xlen-1:0]   mplier_q;
  logic [2*xlen-1:0] acc_q;
  logic              neg_q;
  logic              is_signed;
  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;
  logic              accept;

  // only mul is signed, mulu keeps raw operands
  assign is_signed = (fn == muldiv_pkg::fn_mul);
  assign a_mag     = (is_signed && a[xlen-1]) ? -a : a;
  assign b_mag     = (is_signed && b[xlen-1]) ? -b : b;

  assign req_rdy  = (state_q == st_idle);
  assign resp_val = (state_q == st_done);
  assign accept   = req_val && req_rdy;

  // product sign applied on the way out
  assign result = neg_q ? -acc_q : acc_q;

  // ------------------------------------------------
  // control: idle -> calc (xlen steps + 1) -> done
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q       <= st_idle;
      cnt_q         <= '0;
      cnt_expired_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (accept) begin
            state_q       <= st_calc;
            cnt_q         <= cnt_w'(xlen - 1);
            cnt_expired_q <= 1'b0;
          end
        end
        st_calc: begin
          // last step sets the flag, the cycle after it moves to done
          if (cnt_expired_q) begin
            state_q <= st_done;
          end else if (cnt_q == '0) begin
            cnt_expired_q <= 1'b1;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        st_done: begin
          if (resp_rdy) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------
  // datapath: add shifted multiplicand when the multiplier bit is set
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      mcand_q  <= {{xlen{1'b0}}, a_mag};
      mplier_q <= b_mag;
      acc_q    <= '0;
      neg_q    <= is_signed && (a[xlen-1] ^ b[xlen-1]);
    end else if (state_q == st_calc && !cnt_expired_q) begin
      acc_q    <= acc_q + (mplier_q[0] ? mcand_q : '0);
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // every multiplier bit is consumed before the product is offered
  a_mplier_done: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> (mplier_q == '0));

endmodule

// ==== src/int_div_dpath.sv ====
// ------------------------------------------------
// restoring divider datapath, one quotient bit per cycle
// driven by int_div_ctrl through enables and selects
// ------------------------------------------------
module int_div_dpath #(
  parameter int xlen = muldiv_pkg::xlen_default
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [xlen-1:0]   a,
  input  logic [xlen-1:0]   b,
  input  logic              a_en,
  input  logic              b_en,
  input  logic              a_sel,
  input  logic              sub_sel,
  input  logic              cnt_load,
  input  logic              sign_en,
  input  logic              is_signed,
  output logic [2*xlen-1:0] result,
  output logic              sub_neg,
  output logic              cnt_zero
);
  // remainder register carries one extra bit for the trial sign
  localparam int rw    = 2 * xlen + 1;
  localparam int cnt_w = $clog2(xlen);

  logic [rw-1:0]    rem_q;
  logic [rw-1:0]    dsr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             cnt_expired_q;
  logic             quo_sign_q;
  logic             rem_sign_q;
  logic [xlen-1:0]  a_mag;
  logic [xlen-1:0]  b_mag;
  logic [rw-1:0]    rem_shift;
  logic [rw-1:0]    diff;
  logic [rw-1:0]    step_val;
  logic [rw-1:0]    rem_next;
  logic [xlen-1:0]  quo;
  logic [xlen-1:0]  rem;
  logic             step;

  // ------------------------------------------------
  // operand magnitudes
  // ------------------------------------------------
  assign a_mag = (is_signed && a[xlen-1]) ? -a : a;
  assign b_mag = (is_signed && b[xlen-1]) ? -b : b;

  // ------------------------------------------------
  // shift-subtract step
  // ------------------------------------------------
  assign rem_shift = rem_q << 1;
  assign diff      = rem_shift - dsr_q;
  assign sub_neg   = diff[rw-1];

  // sub_sel high means the trial went negative, so restore with a zero bit
  assign step_val = sub_sel ? {rem_shift[rw-1:1], 1'b0} : {diff[rw-1:1], 1'b1};
  assign rem_next = a_sel ? step_val : {{(xlen + 1){1'b0}}, a_mag};
  assign step     = a_en && a_sel;

  always_ff @(posedge clk) begin
    if (a_en) begin
      rem_q <= rem_next;
    end
    // divisor sits in the upper half, lined up with the remainder
    if (b_en) begin
      dsr_q <= {1'b0, b_mag, {xlen{1'b0}}};
    end
    // unsigned ops load cleared signs so nothing stale is applied
    if (sign_en) begin
      quo_sign_q <= is_signed && (a[xlen-1] ^ b[xlen-1]);
      rem_sign_q <= is_signed && a[xlen-1];
    end
  end

  // ------------------------------------------------
  // step counter, flag marks that the last step is taken
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q         <= '0;
      cnt_expired_q <= 1'b0;
    end else if (cnt_load) begin
      cnt_q         <= cnt_w'(xlen - 1);
      cnt_expired_q <= 1'b0;
    end else if (step) begin
      if (cnt_q == '0) begin
        cnt_expired_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign cnt_zero = cnt_expired_q;

  // ------------------------------------------------
  // result, remainder high and quotient low
  // ------------------------------------------------
  assign quo    = quo_sign_q ? -rem_q[xlen-1:0] : rem_q[xlen-1:0];
  assign rem    = rem_sign_q ? -rem_q[2*xlen-1:xlen] : rem_q[2*xlen-1:xlen];
  assign result = {rem, quo};

endmodule

// ==== src/int_div_ctrl.sv ====
// ------------------------------------------------
// divider control FSM, idle / calc / done
// drives datapath enables and selects from the handshake and status
// ------------------------------------------------
module int_div_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::muldiv_fn_e fn,
  input  logic                   req_val,
  input  logic                   resp_rdy,
  input  logic                   sub_neg,
  input  logic                   cnt_zero,
  output logic                   req_rdy,
  output logic                   resp_val,
  output logic                   a_en,
  output logic                   b_en,
  output logic                   a_sel,
  output logic                   sub_sel,
  output logic                   cnt_load,
  output logic                   sign_en,
  output logic                   is_signed
);
  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_e;

  state_e state_q;
  logic   accept;

  // only div is signed, divu keeps raw operands
  assign is_signed = (fn == muldiv_pkg::fn_div);
  assign accept    = (state_q == st_idle) && req_val;

  // ------------------------------------------------
  // state register
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          if (accept) begin
            state_q <= st_calc;
          end
        end
        st_calc: begin
          if (cnt_zero) begin
            state_q <= st_done;
          end
        end
        // leave done on the response handshake only
        st_done: begin
          if (resp_rdy) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------
  // outputs, decoded from state
  // ------------------------------------------------
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    a_en     = 1'b0;
    b_en     = 1'b0;
    a_sel    = 1'b0;
    sub_sel  = 1'b0;
    cnt_load = 1'b0;
    sign_en  = 1'b0;
    case (state_q)
      st_idle: begin
        req_rdy = 1'b1;
        // load operands, counter and signs on accept
        a_en     = accept;
        b_en     = accept;
        cnt_load = accept;
        sign_en  = accept;
      end
      st_calc: begin
        // one step per cycle until the counter runs out
        a_en    = !cnt_zero;
        a_sel   = 1'b1;
        sub_sel = sub_neg;
      end
      st_done: resp_val = 1'b1;
      default: ;
    endcase
  end

  // the step counter stays run out for as long as the response is offered
  a_done_cnt: assert property (@(posedge clk) disable iff (reset)
    resp_val |-> cnt_zero);

endmodule

// ==== src/int_div_iterative.sv ====
// ------------------------------------------------
// iterative divider, joins control FSM and datapath
// ------------------------------------------------
module int_div_iterative #(
  parameter int xlen = muldiv_pkg::xlen_default
) (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::muldiv_fn_e fn,
  input  logic [xlen-1:0]        a,
  input  logic [xlen-1:0]        b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output logic [2*xlen-1:0]      result,
  output logic                   resp_val,
  input  logic                   resp_rdy
);
  // control to datapath
  logic a_en;
  logic b_en;
  logic a_sel;
  logic sub_sel;
  logic cnt_load;
  logic sign_en;
  logic is_signed;
  // datapath status
  logic sub_neg;
  logic cnt_zero;

  int_div_dpath #(.xlen(xlen)) u_dpath (
    .clk(clk), .reset(reset), .a(a), .b(b),
    .a_en(a_en), .b_en(b_en), .a_sel(a_sel), .sub_sel(sub_sel),
    .cnt_load(cnt_load), .sign_en(sign_en), .is_signed(is_signed),
    .result(result), .sub_neg(sub_neg), .cnt_zero(cnt_zero)
  );

  int_div_ctrl u_ctrl (
    .clk(clk), .reset(reset), .fn(fn), .req_val(req_val), .resp_rdy(resp_rdy),
    .sub_neg(sub_neg), .cnt_zero(cnt_zero), .req_rdy(req_rdy), .resp_val(resp_val),
    .a_en(a_en), .b_en(b_en), .a_sel(a_sel), .sub_sel(sub_sel),
    .cnt_load(cnt_load), .sign_en(sign_en), .is_signed(is_signed)
  );

endmodule

// ==== src/muldiv_unit.sv ====
// ------------------------------------------------
// multiply/divide unit top, one operation in flight
// steers requests by function code, returns the owner's response
// ------------------------------------------------
module muldiv_unit #(
  parameter int xlen = muldiv_pkg::xlen_default
) (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::muldiv_fn_e fn,
  input  logic [xlen-1:0]        a,
  input  logic [xlen-1:0]        b,
  input  logic                   req_val,
  output logic                   req_rdy,
  output logic [2*xlen-1:0]      result,
  output logic                   resp_val,
  input  logic                   resp_rdy
);
  logic              busy_q;
  // owner high means the divider holds the operation
  logic              owner_q;
  logic              sel_div;
  logic              mul_req_val;
  logic              mul_req_rdy;
  logic [2*xlen-1:0] mul_result;
  logic              mul_resp_val;
  logic              mul_resp_rdy;
  logic              div_req_val;
  logic              div_req_rdy;
  logic [2*xlen-1:0] div_result;
  logic              div_resp_val;
  logic              div_resp_rdy;

  assign sel_div = muldiv_pkg::fn_is_div(fn);

  // ------------------------------------------------
  // request steering
  // ------------------------------------------------
  assign mul_req_val = req_val && !busy_q && !sel_div;
  assign div_req_val = req_val && !busy_q && sel_div;
  assign req_rdy     = !busy_q && (sel_div ? div_req_rdy : mul_req_rdy);

  // ------------------------------------------------
  // response from the owner only
  // ------------------------------------------------
  assign resp_val     = busy_q && (owner_q ? div_resp_val : mul_resp_val);
  assign result       = owner_q ? div_result : mul_result;
  assign mul_resp_rdy = resp_rdy && busy_q && !owner_q;
  assign div_resp_rdy = resp_rdy && busy_q && owner_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy_q  <= 1'b1;
      owner_q <= sel_div;
    end else if (resp_val && resp_rdy) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end
  end

  int_mul_iterative #(.xlen(xlen)) u_mul (
    .clk(clk), .reset(reset), .fn(fn), .a(a), .b(b),
    .req_val(mul_req_val), .req_rdy(mul_req_rdy),
    .result(mul_result), .resp_val(mul_resp_val), .resp_rdy(mul_resp_rdy)
  );

  int_div_iterative #(.xlen(xlen)) u_div (
    .clk(clk), .reset(reset), .fn(fn), .a(a), .b(b),
    .req_val(div_req_val), .req_rdy(div_req_rdy),
    .result(div_result), .resp_val(div_resp_val), .resp_rdy(div_resp_rdy)
  );

  // a held response keeps its value through back-pressure
  a_result_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(result)));

endmodule

// ==== verification/muldiv_unit_tb.sv ====
// ------------------------------------------------
// directed testbench for the multiply/divide unit
// each test task drives requests and checks responses against a model
// ------------------------------------------------
module muldiv_unit_tb;
  localparam int xlen = muldiv_pkg::xlen_default;
  // iterative ops take about xlen+2 edges, leave margin
  localparam int wait_limit = 4 * xlen;
  localparam logic [xlen-1:0] all_ones = '1;
  localparam logic [xlen-1:0] min_val = {1'b1, {(xlen - 1){1'b0}}};

  logic                   clk;
  logic                   reset;
  muldiv_pkg::muldiv_fn_e fn;
  logic [xlen-1:0]        a;
  logic [xlen-1:0]        b;
  logic                   req_val;
  logic                   req_rdy;
  logic [2*xlen-1:0]      result;
  logic                   resp_val;
  logic                   resp_rdy;
  logic [31:0]            rng_state;
  // operation being checked, shown in error lines
  string                  op_desc;

  muldiv_unit #(.xlen(xlen)) u_dut (
    .clk(clk), .reset(reset), .fn(fn), .a(a), .b(b),
    .req_val(req_val), .req_rdy(req_rdy),
    .result(result), .resp_val(resp_val), .resp_rdy(resp_rdy)
  );

  always #50 clk = ~clk;

  // ------------------------------------------------
  // helpers: random numbers, reference model, compares
  // ------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // expected {hi, lo}: full product, or {remainder, quotient}
  function automatic logic [2*xlen-1:0] expect_result(input muldiv_pkg::muldiv_fn_e f,
                                                      input logic [xlen-1:0] x,
                                                      input logic [xlen-1:0] y);
    logic [2*xlen-1:0] xs;
    logic [2*xlen-1:0] ys;
    logic [xlen-1:0]   xm;
    logic [xlen-1:0]   ym;
    logic [xlen-1:0]   q;
    logic [xlen-1:0]   r;
    case (f)
      muldiv_pkg::fn_mul: begin
        xs = {{xlen{x[xlen-1]}}, x};
        ys = {{xlen{y[xlen-1]}}, y};
        return xs * ys;
      end
      muldiv_pkg::fn_mulu: begin
        xs = {{xlen{1'b0}}, x};
        ys = {{xlen{1'b0}}, y};
        return xs * ys;
      end
      muldiv_pkg::fn_div: begin
        // magnitudes first, then quotient sign from both, remainder from dividend
        xm = x[xlen-1] ? -x : x;
        ym = y[xlen-1] ? -y : y;
        q  = xm / ym;
        r  = xm % ym;
        if (x[xlen-1] ^ y[xlen-1]) q = -q;
        if (x[xlen-1]) r = -r;
        return {r, q};
      end
      default: begin
        // divu by zero: all-ones quotient, dividend as remainder
        if (y == '0) return {x, all_ones};
        return {x % y, x / y};
      end
    endcase
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "testbench stopped at first error");
  endtask

  task automatic check_result(input string name, input logic [2*xlen-1:0] got,
                              input logic [2*xlen-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] time %0t: %s = %h, expected %h (%s)", $time, name, got, exp, op_desc);
      stop_run("wrong result value");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] time %0t: %s = %b, expected %b (%s)", $time, name, got, exp, op_desc);
      stop_run("wrong handshake level");
    end
  endtask

  // ------------------------------------------------
  // request and response handshakes
  // ------------------------------------------------
  task automatic send_req(input muldiv_pkg::muldiv_fn_e f, input logic [xlen-1:0] x,
                          input logic [xlen-1:0] y);
    int n;
    fn      <= f;
    a       <= x;
    b       <= y;
    req_val <= 1'b1;
    n = 0;
    @(posedge clk);
    while (req_rdy !== 1'b1) begin
      n++;
      if (n > wait_limit) stop_run("timed out waiting for the request to be accepted");
      @(posedge clk);
    end
    // accepted on this edge
    req_val <= 1'b0;
  endtask

  task automatic recv_resp(output logic [2*xlen-1:0] got);
    int n;
    resp_rdy <= 1'b1;
    n = 0;
    @(posedge clk);
    while (resp_val !== 1'b1) begin
      // nothing else may enter while in flight
      check_bit("req_rdy", req_rdy, 1'b0);
      n++;
      if (n > wait_limit) stop_run("timed out waiting for a response");
      @(posedge clk);
    end
    got = result;
    resp_rdy <= 1'b0;
  endtask

  task automatic run_op(input muldiv_pkg::muldiv_fn_e f, input logic [xlen-1:0] x,
                        input logic [xlen-1:0] y);
    logic [2*xlen-1:0] got;
    op_desc = $sformatf("%s a=%h b=%h", f.name(), x, y);
    send_req(f, x, y);
    recv_resp(got);
    check_result("result", got, expect_result(f, x, y));
  endtask

  task automatic div_both(input logic [xlen-1:0] x, input logic [xlen-1:0] y);
    run_op(muldiv_pkg::fn_div, x, y);
    run_op(muldiv_pkg::fn_divu, x, y);
  endtask

  // ------------------------------------------------
  // tests
  // ------------------------------------------------
  task automatic test_reset_state();
    op_desc = "after reset";
    check_bit("req_rdy", req_rdy, 1'b1);
    check_bit("resp_val", resp_val, 1'b0);
  endtask

  task automatic test_mul();
    logic [xlen-1:0] corners [0:3];
    logic [xlen-1:0] x;
    logic [xlen-1:0] y;
    corners[0] = '0;
    corners[1] = xlen'(1);
    corners[2] = all_ones;
    corners[3] = min_val;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        run_op(muldiv_pkg::fn_mul, corners[i], corners[j]);
        run_op(muldiv_pkg::fn_mulu, corners[i], corners[j]);
      end
    end
    repeat (40) begin
      x = xlen'(next_rand());
      y = xlen'(next_rand());
      run_op(muldiv_pkg::fn_mul, x, y);
      run_op(muldiv_pkg::fn_mulu, x, y);
    end
  endtask

  task automatic test_div();
    logic [xlen-1:0] x;
    logic [xlen-1:0] y;
    // sign mixes, all with a nonzero divisor
    div_both(xlen'(7), xlen'(2));
    div_both(xlen'(-7), xlen'(2));
    div_both(xlen'(7), xlen'(-2));
    div_both(xlen'(-7), xlen'(-2));
    div_both(min_val, all_ones);
    div_both(min_val, xlen'(1));
    div_both(all_ones, min_val);
    div_both('0, xlen'(5));
    div_both(xlen'(3), xlen'(9));
    repeat (40) begin
      x = xlen'(next_rand());
      // shift the divisor down so quotients vary in size
      y = xlen'(next_rand()) >> (next_rand() % xlen);
      if (y == '0) y = xlen'(1);
      div_both(x, y);
    end
  endtask

  task automatic test_divu_zero();
    run_op(muldiv_pkg::fn_divu, '0, '0);
    run_op(muldiv_pkg::fn_divu, all_ones, '0);
    run_op(muldiv_pkg::fn_divu, min_val, '0);
    repeat (4) run_op(muldiv_pkg::fn_divu, xlen'(next_rand()), '0);
  endtask

  task automatic test_backpressure();
    muldiv_pkg::muldiv_fn_e f;
    logic [xlen-1:0]        x;
    logic [xlen-1:0]        y;
    logic [2*xlen-1:0]      held;
    int                     hold;
    int                     n;
    for (int i = 0; i < 6; i++) begin
      f    = (i % 2 == 0) ? muldiv_pkg::fn_mul : muldiv_pkg::fn_divu;
      x    = xlen'(next_rand());
      y    = xlen'(next_rand());
      hold = int'(next_rand() % 21);
      op_desc = $sformatf("held %s a=%h b=%h", f.name(), x, y);
      send_req(f, x, y);
      n = 0;
      @(posedge clk);
      while (resp_val !== 1'b1) begin
        n++;
        if (n > wait_limit) stop_run("timed out waiting for a held response");
        @(posedge clk);
      end
      held = result;
      check_result("result", held, expect_result(f, x, y));
      // resp_rdy stays low, everything must hold
      repeat (hold) begin
        @(posedge clk);
        check_bit("resp_val", resp_val, 1'b1);
        check_result("result", result, held);
        check_bit("req_rdy", req_rdy, 1'b0);
      end
      resp_rdy <= 1'b1;
      @(posedge clk);
      check_bit("resp_val", resp_val, 1'b1);
      check_result("result", result, held);
      resp_rdy <= 1'b0;
      // one transfer only
      @(posedge clk);
      check_bit("resp_val", resp_val, 1'b0);
    end
  endtask

  task automatic test_alternate();
    logic [xlen-1:0] y;
    repeat (8) begin
      run_op(muldiv_pkg::fn_mul, xlen'(next_rand()), xlen'(next_rand()));
      y = xlen'(next_rand());
      if (y == '0) y = all_ones;
      run_op(muldiv_pkg::fn_div, xlen'(next_rand()), y);
    end
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    fn        = muldiv_pkg::fn_mul;
    a         = '0;
    b         = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    rng_state = 32'hf9f2_e463;
    op_desc   = "reset";
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_reset_state();
    test_mul();
    test_div();
    test_divu_zero();
    test_backpressure();
    test_alternate();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== muldiv_unit.f ====
src/muldiv_pkg.sv
src/int_mul_iterative.sv
src/int_div_dpath.sv
src/int_div_ctrl.sv
src/int_div_iterative.sv
src/muldiv_unit.sv
verification/muldiv_unit_tb.sv

// ==== build.sh ====
#!/bin/sh
# compile the multiply/divide unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module muldiv_unit_tb -f muldiv_unit.f \
  -Mdir obj_dir -o muldiv_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "build.sh: verilator compile failed with status $build_status"
  exit 1
fi

./obj_dir/muldiv_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "build.sh: simulation reported a failure"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "build.sh: simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "build.sh: simulation ended without a verdict"
  exit 1
fi
exit 0
